// ==== Bender.yml ====
package:
  name: wb_shared_bus

sources:
  # package first, then the RTL in dependency order
  - verilog/wb_bus_pkg.sv
  - verilog/wb_if.sv
  - verilog/round_robin_arbiter.sv
  - verilog/bus_cycle_fsm.sv
  - verilog/cycle_timer.sv
  - verilog/master_mux.sv
  - verilog/sram_slave.sv
  - verilog/wb_shared_bus.sv
  - target: test
    files:
      - tb/tb_wb_shared_bus.sv

// ==== tb/tb_wb_shared_bus.sv ====
/* Directed testbench for the shared Wishbone bus: data, round-robin order and
   timeout checks against a reference memory model, guarded by a watchdog. */
`timescale 1ns/1ps

module tb_wb_shared_bus;

	localparam int NUM_MASTERS = 4;
	localparam int MEM_WORDS = 256;
	localparam int WAIT_STATES = 2;
	localparam int TIMEOUT_CYCLES = 16;
	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 16;
	localparam int RR_ROUNDS = 2;
	localparam int STREAM_LEN = 4;
	// 64 + 8 + 9 + 3 + 3 + 32 transfers over all tests
	localparam int NUM_TRANSFERS = 119;
	localparam int XFER_LIMIT = NUM_MASTERS * (WAIT_STATES + 4 + TIMEOUT_CYCLES);
	localparam int WATCHDOG_NS =
		(NUM_TRANSFERS * (WAIT_STATES + 4 + TIMEOUT_CYCLES) + RESET_CYCLES + 100) * CLK_PERIOD;

	logic                   clk;
	logic                   rst_an;
	logic [NUM_MASTERS-1:0] m_cyc;
	logic [NUM_MASTERS-1:0] m_stb;
	logic [NUM_MASTERS-1:0] m_we;
	wb_bus_pkg::adr_t       m_adr [NUM_MASTERS];
	wb_bus_pkg::dat_t       m_dat_w [NUM_MASTERS];
	wb_bus_pkg::dat_t       m_dat_r [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] m_ack;
	logic [NUM_MASTERS-1:0] m_err;

	// reference memory, zero until written
	wb_bus_pkg::dat_t ref_mem [MEM_WORDS];
	// masters in the order their cycles ended
	int               served_q [$];
	wb_bus_pkg::adr_t stream_adr [NUM_MASTERS][STREAM_LEN];
	wb_bus_pkg::dat_t stream_dat [NUM_MASTERS][STREAM_LEN];
	logic [31:0]      lcg_state = 32'hb4feea1c;
	int               errors = 0;
	int               checks = 0;
	int               tests = 0;

	wb_shared_bus #(
		.NUM_MASTERS   (NUM_MASTERS),
		.MEM_WORDS     (MEM_WORDS),
		.WAIT_STATES   (WAIT_STATES),
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) wb_shared_bus_inst (
		.clk    (clk),
		.rst_an (rst_an),
		.m_cyc  (m_cyc),
		.m_stb  (m_stb),
		.m_we   (m_we),
		.m_adr  (m_adr),
		.m_dat_w(m_dat_w),
		.m_dat_r(m_dat_r),
		.m_ack  (m_ack),
		.m_err  (m_err)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// lowest requester above last, else lowest requester overall
	function automatic int rr_expected(input logic [NUM_MASTERS-1:0] reqs, input int last);
		int pick;
		pick = -1;
		for (int i = NUM_MASTERS - 1; i > last; i--) begin
			if (reqs[i]) begin
				pick = i;
			end
		end
		if (pick < 0) begin
			for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
				if (reqs[i]) begin
					pick = i;
				end
			end
		end
		return pick;
	endfunction

	task automatic check_dat(input string name, input wb_bus_pkg::dat_t exp_val,
		input wb_bus_pkg::dat_t got_val);
		checks++;
		if (got_val !== exp_val) begin
			$display("Mismatch %s: expected 0x%08h got 0x%08h", name, exp_val, got_val);
			errors++;
		end
	endtask

	task automatic check_grant_order(input int pos, input int exp_idx, input int got_idx);
		checks++;
		if (got_idx != exp_idx) begin
			$display("Mismatch served_master[%0d]: expected 0x%0h got 0x%0h",
				pos, exp_idx, got_idx);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic got_val);
		checks++;
		if (got_val !== exp_val) begin
			$display("Mismatch %s: expected 0x%0h got 0x%0h", name, exp_val, got_val);
			errors++;
		end
	endtask

	// one classic transfer for master m, entered and left 1 ns after a rising edge
	task automatic bus_transfer(input int m, input logic we, input wb_bus_pkg::adr_t adr,
		input wb_bus_pkg::dat_t wdat, output wb_bus_pkg::dat_t rdat,
		output logic got_err, output int cycles);
		logic                   done;
		logic [NUM_MASTERS-1:0] own_bit;
		own_bit = '0;
		own_bit[m] = 1'b1;
		m_adr[m] = adr;
		m_dat_w[m] = wdat;
		m_we[m] = we;
		m_cyc[m] = 1'b1;
		m_stb[m] = 1'b1;
		cycles = 0;
		done = 1'b0;
		rdat = '0;
		got_err = 1'b0;
		while (!done) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			if (m_ack[m] || m_err[m]) begin
				done = 1'b1;
				rdat = m_dat_r[m];
				got_err = m_err[m];
				served_q.push_back(m);
				// ack and err go to the owner alone
				if (((m_ack | m_err) & ~own_bit) != '0) begin
					$display("ERROR: master %0d finished while another master saw ack or err",
						m);
					errors++;
				end
			end else if (cycles > XFER_LIMIT) begin
				$display("ERROR: master %0d got neither ack nor err in %0d cycles",
					m, XFER_LIMIT);
				errors++;
				done = 1'b1;
				got_err = 1'bx;
			end
		end
		// drop the request, stay off through the release cycle
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		m_we[m] = 1'b0;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %-24s ok", name);
		end else begin
			$display("test %-24s FAILED with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_write_read();
		int               errs_before;
		wb_bus_pkg::adr_t adr_list [32];
		wb_bus_pkg::dat_t wdat;
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		errs_before = errors;
		// lower half only, upper half stays unwritten for the zero test
		for (int i = 0; i < 32; i++) begin
			adr_list[i] = wb_bus_pkg::adr_t'((next_rand() >> 8) % (MEM_WORDS / 2));
			wdat = next_rand();
			bus_transfer(0, 1'b1, adr_list[i], wdat, rdat, is_err, cycles);
			check_flag("m_err[0]", 1'b0, is_err);
			ref_mem[adr_list[i]] = wdat;
		end
		for (int i = 0; i < 32; i++) begin
			bus_transfer(0, 1'b0, adr_list[i], '0, rdat, is_err, cycles);
			check_flag("m_err[0]", 1'b0, is_err);
			check_dat("m_dat_r[0]", ref_mem[adr_list[i]], rdat);
		end
		report_test("write_read", errs_before);
	endtask

	task automatic test_unwritten_zero();
		int               errs_before;
		wb_bus_pkg::adr_t adr;
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		errs_before = errors;
		for (int i = 0; i < 8; i++) begin
			adr = wb_bus_pkg::adr_t'(MEM_WORDS / 2 + (next_rand() >> 8) % (MEM_WORDS / 2));
			bus_transfer(0, 1'b0, adr, '0, rdat, is_err, cycles);
			check_flag("m_err[0]", 1'b0, is_err);
			check_dat("m_dat_r[0]", ref_mem[adr], rdat);
		end
		report_test("unwritten_zero", errs_before);
	endtask

	// back-to-back reads, request raised again during the release cycle
	task automatic repeat_reads(input int m, input int rounds);
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		for (int r = 0; r < rounds; r++) begin
			bus_transfer(m, 1'b0, wb_bus_pkg::adr_t'(m), '0, rdat, is_err, cycles);
			check_flag($sformatf("m_err[%0d]", m), 1'b0, is_err);
			check_dat($sformatf("m_dat_r[%0d]", m), ref_mem[m], rdat);
		end
	endtask

	task automatic compare_order(input int exp_q [$]);
		if (served_q.size() != exp_q.size()) begin
			$display("ERROR: %0d cycles were served where %0d were expected",
				served_q.size(), exp_q.size());
			errors++;
		end else begin
			for (int n = 0; n < exp_q.size(); n++) begin
				check_grant_order(n, exp_q[n], served_q[n]);
			end
		end
	endtask

	task automatic test_round_robin();
		int                     errs_before;
		int                     remaining [NUM_MASTERS];
		logic [NUM_MASTERS-1:0] reqs;
		int                     last;
		int                     exp_q [$];
		wb_bus_pkg::dat_t       rdat;
		logic                   is_err;
		int                     cycles;
		errs_before = errors;
		// serving master 3 first wraps the pointer back to everyone
		bus_transfer(3, 1'b0, '0, '0, rdat, is_err, cycles);
		last = 3;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			remaining[i] = RR_ROUNDS;
		end
		for (int n = 0; n < NUM_MASTERS * RR_ROUNDS; n++) begin
			for (int i = 0; i < NUM_MASTERS; i++) begin
				reqs[i] = remaining[i] > 0;
			end
			last = rr_expected(reqs, last);
			exp_q.push_back(last);
			remaining[last]--;
		end
		served_q.delete();
		fork
			repeat_reads(0, RR_ROUNDS);
			repeat_reads(1, RR_ROUNDS);
			repeat_reads(2, RR_ROUNDS);
			repeat_reads(3, RR_ROUNDS);
		join
		compare_order(exp_q);
		report_test("round_robin", errs_before);
	endtask

	task automatic test_partial_requests();
		int               errs_before;
		int               exp_q [$];
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		errs_before = errors;
		bus_transfer(2, 1'b0, '0, '0, rdat, is_err, cycles);
		exp_q.push_back(rr_expected(4'b1010, 2));
		exp_q.push_back(rr_expected(4'b0010, exp_q[0]));
		served_q.delete();
		fork
			repeat_reads(1, 1);
			repeat_reads(3, 1);
		join
		compare_order(exp_q);
		report_test("partial_requests", errs_before);
	endtask

	task automatic test_timeout();
		int               errs_before;
		wb_bus_pkg::adr_t bad_adr;
		wb_bus_pkg::adr_t good_adr;
		wb_bus_pkg::dat_t wdat;
		wb_bus_pkg::dat_t rdat_bad;
		wb_bus_pkg::dat_t rdat;
		logic             err_bad;
		logic             err_good;
		int               cyc_bad;
		int               cyc_good;
		errs_before = errors;
		bad_adr = wb_bus_pkg::adr_t'(MEM_WORDS + (next_rand() >> 8) % 1024);
		good_adr = wb_bus_pkg::adr_t'((next_rand() >> 8) % MEM_WORDS);
		wdat = next_rand();
		fork
			bus_transfer(1, 1'b0, bad_adr, '0, rdat_bad, err_bad, cyc_bad);
			begin
				// master 2 asks while master 1 owns the bus
				repeat (3) @(posedge clk);
				#DRIVE_DELAY;
				bus_transfer(2, 1'b1, good_adr, wdat, rdat, err_good, cyc_good);
			end
		join
		check_flag("m_err[1]", 1'b1, err_bad);
		if (cyc_bad < TIMEOUT_CYCLES) begin
			$display("ERROR: err reached master 1 after %0d cycles, before the %0d cycle limit",
				cyc_bad, TIMEOUT_CYCLES);
			errors++;
		end
		check_flag("m_err[2]", 1'b0, err_good);
		ref_mem[good_adr] = wdat;
		bus_transfer(2, 1'b0, good_adr, '0, rdat, err_good, cyc_good);
		check_flag("m_err[2]", 1'b0, err_good);
		check_dat("m_dat_r[2]", ref_mem[good_adr], rdat);
		report_test("timeout", errs_before);
	endtask

	task automatic write_stream(input int m);
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		for (int k = 0; k < STREAM_LEN; k++) begin
			bus_transfer(m, 1'b1, stream_adr[m][k], stream_dat[m][k], rdat, is_err, cycles);
			check_flag($sformatf("m_err[%0d]", m), 1'b0, is_err);
		end
	endtask

	// reads back the words written by the previous master
	task automatic read_stream(input int m);
		int               src;
		wb_bus_pkg::dat_t rdat;
		logic             is_err;
		int               cycles;
		src = (m + NUM_MASTERS - 1) % NUM_MASTERS;
		for (int k = 0; k < STREAM_LEN; k++) begin
			bus_transfer(m, 1'b0, stream_adr[src][k], '0, rdat, is_err, cycles);
			check_flag($sformatf("m_err[%0d]", m), 1'b0, is_err);
			check_dat($sformatf("m_dat_r[%0d]", m), ref_mem[stream_adr[src][k]], rdat);
		end
	endtask

	task automatic test_contention();
		int               errs_before;
		logic             used [MEM_WORDS];
		wb_bus_pkg::adr_t adr;
		errs_before = errors;
		for (int i = 0; i < MEM_WORDS; i++) begin
			used[i] = 1'b0;
		end
		// distinct addresses, so write order between masters does not matter
		for (int m = 0; m < NUM_MASTERS; m++) begin
			for (int k = 0; k < STREAM_LEN; k++) begin
				do begin
					adr = wb_bus_pkg::adr_t'((next_rand() >> 8) % MEM_WORDS);
				end while (used[adr]);
				used[adr] = 1'b1;
				stream_adr[m][k] = adr;
				stream_dat[m][k] = next_rand();
				ref_mem[adr] = stream_dat[m][k];
			end
		end
		fork
			write_stream(0);
			write_stream(1);
			write_stream(2);
			write_stream(3);
		join
		fork
			read_stream(0);
			read_stream(1);
			read_stream(2);
			read_stream(3);
		join
		report_test("contention", errs_before);
	endtask

	initial begin
		clk = 1'b0;
		rst_an = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_adr[i] = '0;
			m_dat_w[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_an = 1'b1;
		test_write_read();
		test_unwritten_zero();
		test_round_robin();
		test_partial_requests();
		test_timeout();
		test_contention();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// worst case every transfer runs into the timeout
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog/bus_cycle_fsm.sv ====
/* Bus-cycle FSM: takes one grant at a time, owns the bus until ack or err,
   then spends one release cycle before the next arbitration. */
`timescale 1ns/1ps

module bus_cycle_fsm #(
	parameter int NUM_MASTERS = 4
) (
	input  logic                   clk,
	input  logic                   rst_an,
	input  logic [NUM_MASTERS-1:0] grant,
	input  logic                   grant_valid,
	input  logic                   bus_ack,
	input  logic                   bus_err,
	output logic                   accept,
	output logic [NUM_MASTERS-1:0] owner,
	output logic                   owned,
	output logic                   count_en
);

	wb_bus_pkg::bus_state_e state;
	wb_bus_pkg::bus_state_e state_next;

	// grant is taken only from IDLE
	assign accept = (state == wb_bus_pkg::IDLE) && grant_valid;

	assign owned = (state == wb_bus_pkg::OWNED);

	// timer runs for the whole owned period
	assign count_en = owned;

	always_comb begin
		state_next = state;
		case (state)
			wb_bus_pkg::IDLE: begin
				if (grant_valid) begin
					state_next = wb_bus_pkg::OWNED;
				end
			end
			wb_bus_pkg::OWNED: begin
				// slave ack or timeout err ends the cycle
				if (bus_ack || bus_err) begin
					state_next = wb_bus_pkg::RELEASE;
				end
			end
			wb_bus_pkg::RELEASE: begin
				// finished master has dropped stb by now
				state_next = wb_bus_pkg::IDLE;
			end
			default: begin
				state_next = wb_bus_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			state <= wb_bus_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// owner latched with the accepted grant, held through OWNED and RELEASE
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			owner <= '0;
		end else if (accept) begin
			owner <= grant;
		end
	end

endmodule

// ==== verilog/cycle_timer.sv ====
/* Wait-cycle counter for one bus cycle.
   Flags a timeout once the owned period reaches TIMEOUT_CYCLES without an ack. */
`timescale 1ns/1ps

module cycle_timer #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input  logic clk,
	input  logic rst_an,
	input  logic count_en,
	output logic timeout
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES);

	logic [CNT_W-1:0] count;

	// clears whenever the FSM leaves OWNED
	// saturates at the limit so timeout stays up until then
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			count <= '0;
		end else if (!count_en) begin
			count <= '0;
		end else if (count != LIMIT) begin
			count <= count + 1'b1;
		end
	end

	// mux gates this with owned, so err reaches the master once
	assign timeout = (count == LIMIT);

endmodule

// ==== verilog/master_mux.sv ====
/* Routes the owning master's request onto the slave bus and steers ack, err
   and read data back. The timeout is merged into err here. */
`timescale 1ns/1ps

module master_mux #(
	parameter int NUM_MASTERS = 4
) (
	input  logic [NUM_MASTERS-1:0] owner,
	input  logic                   owned,
	input  logic                   timeout,
	input  logic [NUM_MASTERS-1:0] m_cyc,
	input  logic [NUM_MASTERS-1:0] m_stb,
	input  logic [NUM_MASTERS-1:0] m_we,
	input  wb_bus_pkg::adr_t       m_adr [NUM_MASTERS],
	input  wb_bus_pkg::dat_t       m_dat_w [NUM_MASTERS],
	output wb_bus_pkg::dat_t       m_dat_r [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] m_ack,
	output logic [NUM_MASTERS-1:0] m_err,
	output logic                   bus_ack,
	output logic                   bus_err,
	wb_if.master                   bus
);

	// and-or select over the one-hot owner
	always_comb begin
		logic             sel_cyc;
		logic             sel_stb;
		logic             sel_we;
		wb_bus_pkg::adr_t sel_adr;
		wb_bus_pkg::dat_t sel_dat;
		sel_cyc = 1'b0;
		sel_stb = 1'b0;
		sel_we = 1'b0;
		sel_adr = '0;
		sel_dat = '0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			sel_cyc |= m_cyc[i] & owner[i];
			sel_stb |= m_stb[i] & owner[i];
			sel_we |= m_we[i] & owner[i];
			sel_adr |= m_adr[i] & {wb_bus_pkg::ADDR_W{owner[i]}};
			sel_dat |= m_dat_w[i] & {wb_bus_pkg::DATA_W{owner[i]}};
		end
		// slave sees a cycle only while the FSM owns the bus
		bus.cyc = owned & sel_cyc;
		bus.stb = owned & sel_stb;
		bus.we = sel_we;
		bus.adr = sel_adr;
		bus.dat_w = sel_dat;
	end

	// timeout forced onto err
	assign bus_ack = owned & bus.ack;
	assign bus_err = owned & (bus.err | timeout);

	// only the owner sees ack and err, read data goes to all
	assign m_ack = owner & {NUM_MASTERS{bus_ack}};
	assign m_err = owner & {NUM_MASTERS{bus_err}};

	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_dat_r[i] = bus.dat_r;
		end
	end

endmodule

// ==== verilog/round_robin_arbiter.sv ====
/* Round-robin arbiter built from a masked and an unmasked fixed-priority picker.
   The mask rotates past the master just served, only when the FSM accepts. */
`timescale 1ns/1ps

module round_robin_arbiter #(
	parameter int NUM_MASTERS = 4
) (
	input  logic                   clk,
	input  logic                   rst_an,
	input  logic [NUM_MASTERS-1:0] req,
	input  logic                   accept,
	output logic [NUM_MASTERS-1:0] grant,
	output logic                   grant_valid
);

	// rotating mask where a set bit lets that master win the masked pick
	logic [NUM_MASTERS-1:0] mask_ptr;
	logic [NUM_MASTERS-1:0] mask_next;
	logic [NUM_MASTERS-1:0] mask_req;
	logic [NUM_MASTERS-1:0] mask_grant;
	logic [NUM_MASTERS-1:0] nomask_grant;
	logic                   no_mask_req;

	// one-hot pick of the lowest requesting index
	function automatic logic [NUM_MASTERS-1:0] pick_lowest(
		input logic [NUM_MASTERS-1:0] r
	);
		logic [NUM_MASTERS-1:0] g;
		logic                   found;
		g = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			if (r[i] && !found) begin
				g[i] = 1'b1;
				found = 1'b1;
			end
		end
		return g;
	endfunction

	// requests still inside the mask
	assign mask_req = req & mask_ptr;
	assign no_mask_req = ~|mask_req;

	assign mask_grant = pick_lowest(mask_req);
	assign nomask_grant = pick_lowest(req);

	// unmasked picker only when the mask leaves nobody
	assign grant = no_mask_req ? nomask_grant : mask_grant;
	assign grant_valid = |req;

	// allow only indices above the granted one
	// top master served means everyone is allowed again
	always_comb begin
		logic below;
		below = 1'b0;
		mask_next[0] = grant[NUM_MASTERS-1];
		for (int i = 1; i < NUM_MASTERS; i++) begin
			// running or of the grant bits under i
			below = below | grant[i-1];
			mask_next[i] = grant[NUM_MASTERS-1] | below;
		end
	end

	// pointer moves only when a grant is taken
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			mask_ptr <= '1;
		end else if (accept) begin
			mask_ptr <= mask_next;
		end
	end

endmodule

// ==== verilog/sram_slave.sv ====
/* Word-addressed on-chip SRAM slave with WAIT_STATES wait cycles before ack.
   Addresses at or above MEM_WORDS are never acked. */
`timescale 1ns/1ps

module sram_slave #(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_STATES = 2
) (
	input  logic clk,
	input  logic rst_an,
	wb_if.slave  bus
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int WS_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [WS_W-1:0] WS_LAST = WS_W'(WAIT_STATES);

	wb_bus_pkg::dat_t mem [MEM_WORDS];
	// per-word written flag, unwritten words read as zero
	logic [MEM_WORDS-1:0] valid;
	logic [WS_W-1:0]      wait_cnt;
	logic [IDX_W-1:0]     idx;
	logic                 in_range;
	logic                 hit;

	assign idx = bus.adr[IDX_W-1:0];
	assign in_range = int'(bus.adr) < MEM_WORDS;
	// transfer completes on this edge
	assign hit = bus.cyc && bus.stb && in_range && !bus.ack && (wait_cnt == WS_LAST);

	// ack is one cycle wide, then wait counter restarts
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			wait_cnt <= '0;
			bus.ack <= 1'b0;
			valid <= '0;
		end else if (bus.ack) begin
			wait_cnt <= '0;
			bus.ack <= 1'b0;
		end else if (bus.cyc && bus.stb && in_range) begin
			if (hit) begin
				bus.ack <= 1'b1;
				if (bus.we) begin
					valid[idx] <= 1'b1;
				end
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end else begin
			wait_cnt <= '0;
		end
	end

	// storage and read data
	always_ff @(posedge clk) begin
		if (hit && bus.we) begin
			mem[idx] <= bus.dat_w;
		end
		if (hit && !bus.we) begin
			bus.dat_r <= valid[idx] ? mem[idx] : '0;
		end
	end

	// no error source here, out-of-range cycles end on the timer
	assign bus.err = 1'b0;

endmodule

// ==== verilog/wb_bus_pkg.sv ====
/* Shared widths, bus word types and bus-cycle states for the Wishbone shared bus.
   Modules refer to these through scoped names. */
package wb_bus_pkg;

	// word address width, one address per 32-bit word
	localparam int ADDR_W = 16;

	// data width, full word only (no byte selects)
	localparam int DATA_W = 32;

	// word address on the bus
	typedef logic [ADDR_W-1:0] adr_t;

	// data word on the bus
	typedef logic [DATA_W-1:0] dat_t;

	// bus-cycle states
	typedef enum logic [1:0] {
		// no owner, waiting for a grant
		IDLE    = 2'd0,
		// cycle in progress for the latched owner
		OWNED   = 2'd1,
		// one cycle for the finished master to drop cyc
		RELEASE = 2'd2
	} bus_state_e;

endpackage

// ==== verilog/wb_if.sv ====
/* Wishbone classic single-transfer interface.
   The mux uses the master modport, the SRAM the slave modport. */
`timescale 1ns/1ps

interface wb_if;

	// request side, driven by the master
	logic cyc;
	logic stb;
	logic we;
	wb_bus_pkg::adr_t adr;
	wb_bus_pkg::dat_t dat_w;

	// response side, driven by the slave
	wb_bus_pkg::dat_t dat_r;
	logic ack;
	logic err;

	// master holds cyc/stb until ack or err, then drops stb
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  dat_r,
		input  ack,
		input  err
	);

	// slave answers with one-cycle ack or err
	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output dat_r,
		output ack,
		output err
	);

endinterface

// ==== verilog/wb_shared_bus.sv ====
/* Top level of the shared Wishbone classic bus: NUM_MASTERS masters on plain
   ports share one SRAM slave through a round-robin arbiter. */
`timescale 1ns/1ps

module wb_shared_bus #(
	parameter int NUM_MASTERS    = 4,
	parameter int MEM_WORDS      = 256,
	parameter int WAIT_STATES    = 2,
	parameter int TIMEOUT_CYCLES = 16
) (
	input  logic                   clk,
	input  logic                   rst_an,
	input  logic [NUM_MASTERS-1:0] m_cyc,
	input  logic [NUM_MASTERS-1:0] m_stb,
	input  logic [NUM_MASTERS-1:0] m_we,
	input  wb_bus_pkg::adr_t       m_adr [NUM_MASTERS],
	input  wb_bus_pkg::dat_t       m_dat_w [NUM_MASTERS],
	output wb_bus_pkg::dat_t       m_dat_r [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] m_ack,
	output logic [NUM_MASTERS-1:0] m_err
);

	logic [NUM_MASTERS-1:0] req;
	logic [NUM_MASTERS-1:0] grant;
	logic                   grant_valid;
	logic                   accept;
	logic [NUM_MASTERS-1:0] owner;
	logic                   owned;
	logic                   count_en;
	logic                   timeout;
	logic                   bus_ack;
	logic                   bus_err;

	// single link between mux and SRAM
	wb_if bus_if ();

	// a request needs both cyc and stb
	assign req = m_cyc & m_stb;

	round_robin_arbiter #(
		.NUM_MASTERS(NUM_MASTERS)
	) round_robin_arbiter_inst (
		.clk        (clk),
		.rst_an     (rst_an),
		.req        (req),
		.accept     (accept),
		.grant      (grant),
		.grant_valid(grant_valid)
	);

	bus_cycle_fsm #(
		.NUM_MASTERS(NUM_MASTERS)
	) bus_cycle_fsm_inst (
		.clk        (clk),
		.rst_an     (rst_an),
		.grant      (grant),
		.grant_valid(grant_valid),
		.bus_ack    (bus_ack),
		.bus_err    (bus_err),
		.accept     (accept),
		.owner      (owner),
		.owned      (owned),
		.count_en   (count_en)
	);

	cycle_timer #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) cycle_timer_inst (
		.clk     (clk),
		.rst_an  (rst_an),
		.count_en(count_en),
		.timeout (timeout)
	);

	master_mux #(
		.NUM_MASTERS(NUM_MASTERS)
	) master_mux_inst (
		.owner  (owner),
		.owned  (owned),
		.timeout(timeout),
		.m_cyc  (m_cyc),
		.m_stb  (m_stb),
		.m_we   (m_we),
		.m_adr  (m_adr),
		.m_dat_w(m_dat_w),
		.m_dat_r(m_dat_r),
		.m_ack  (m_ack),
		.m_err  (m_err),
		.bus_ack(bus_ack),
		.bus_err(bus_err),
		.bus    (bus_if.master)
	);

	sram_slave #(
		.MEM_WORDS  (MEM_WORDS),
		.WAIT_STATES(WAIT_STATES)
	) sram_slave_inst (
		.clk   (clk),
		.rst_an(rst_an),
		.bus   (bus_if.slave)
	);

endmodule

// ==== wb_shared_bus.f ====
verilog/wb_bus_pkg.sv
verilog/wb_if.sv
verilog/round_robin_arbiter.sv
verilog/bus_cycle_fsm.sv
verilog/cycle_timer.sv
verilog/master_mux.sv
verilog/sram_slave.sv
verilog/wb_shared_bus.sv
tb/tb_wb_shared_bus.sv
